//--- design/ntm_gate_combiner.sv
// Gate combiner with run control, partial sum and bias addition, hard sigmoid and READY
`timescale 1ns/10ps
`include "ntm_gate_defs.svh"

module ntm_gate_combiner (
  // Clock and reset
  input  logic                     CLK,
  input  logic                     RST,

  // Run control
  input  logic                     START,
  input  ntm_gate_pkg::gate_size_t size_rows,
  output logic                     run_start,

  // Partial sums from the two engines
  input  logic                     input_done,
  input  ntm_gate_pkg::gate_acc_t  input_sum,
  input  logic                     recurrent_done,
  input  ntm_gate_pkg::gate_acc_t  recurrent_sum,

  // Bias, one per row
  input  logic                     bias_enable,
  input  ntm_gate_pkg::gate_data_t bias_in,

  // Gate output and end of run
  output logic                     gate_enable,
  output ntm_gate_pkg::gate_out_t  gate_out,
  output logic                     READY
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  // Two guard bits over the accumulator for the three-term sum
  localparam int Z_WIDTH = `NTM_ACC_WIDTH + 2;

  // z is at 2^-16, z/4 back in Q8.8 needs FRAC_BITS + 2
  localparam int SHIFT = `NTM_FRAC_BITS + 2;

  // 0.5 and 1.0 in Q8.8
  localparam logic signed [Z_WIDTH-1:0] HALF_Q = 2 ** (`NTM_FRAC_BITS - 1);
  localparam logic signed [Z_WIDTH-1:0] ONE_Q  = 2 ** `NTM_FRAC_BITS;

  // Run state
  logic                     busy_q;
  logic                     finish_q;
  ntm_gate_pkg::gate_size_t rows_q;
  ntm_gate_pkg::gate_size_t row_cnt_q;
  ntm_gate_pkg::gate_size_t row_cnt_next;
  logic                     last_row;

  // Held row operands and their valid flags
  ntm_gate_pkg::gate_acc_t  in_sum_q;
  ntm_gate_pkg::gate_acc_t  rec_sum_q;
  ntm_gate_pkg::gate_data_t bias_q;
  logic                     in_valid_q;
  logic                     rec_valid_q;
  logic                     bias_valid_q;
  logic                     all_valid;

  // Sum and activation
  logic signed [Z_WIDTH-1:0] in_ext;
  logic signed [Z_WIDTH-1:0] rec_ext;
  logic signed [Z_WIDTH-1:0] bias_ext;
  logic signed [Z_WIDTH-1:0] z;
  logic signed [Z_WIDTH-1:0] z_scaled;
  ntm_gate_pkg::gate_out_t   sig_value;

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  // START taken only when idle, so engines sample sizes on the same edge
  assign run_start = START && !busy_q;

  assign all_valid    = in_valid_q && rec_valid_q && bias_valid_q;
  assign row_cnt_next = row_cnt_q + ntm_gate_pkg::gate_size_t'(1);
  assign last_row     = (row_cnt_next == rows_q);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q       <= 1'b0;
      finish_q     <= 1'b0;
      rows_q       <= '0;
      row_cnt_q    <= '0;
      in_valid_q   <= 1'b0;
      rec_valid_q  <= 1'b0;
      bias_valid_q <= 1'b0;
      gate_enable  <= 1'b0;
      READY        <= 1'b0;
    end else begin
      gate_enable <= 1'b0;
      // READY trails the last gate_enable by one cycle
      READY       <= finish_q;
      finish_q    <= 1'b0;

      if (finish_q) begin
        busy_q <= 1'b0;
      end

      if (run_start) begin
        busy_q    <= 1'b1;
        rows_q    <= size_rows;
        row_cnt_q <= '0;
      end

      // Flags drop when the row is emitted, a new arrival sets them again
      in_valid_q   <= (in_valid_q && !all_valid) || input_done;
      rec_valid_q  <= (rec_valid_q && !all_valid) || recurrent_done;
      bias_valid_q <= (bias_valid_q && !all_valid) || (bias_enable && busy_q);

      if (all_valid) begin
        gate_enable <= 1'b1;
        if (last_row) begin
          finish_q  <= 1'b1;
          row_cnt_q <= '0;
        end else begin
          row_cnt_q <= row_cnt_next;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sum and hard sigmoid
  ////////////////////////////////////////////////////////////////////////////

  assign in_ext   = in_sum_q;
  assign rec_ext  = rec_sum_q;
  assign bias_ext = bias_q;

  // Bias moved from 2^-8 to 2^-16 units
  assign z = in_ext + rec_ext + (bias_ext <<< `NTM_FRAC_BITS);

  // Arithmetic shift floors toward minus infinity
  assign z_scaled = (z >>> SHIFT) + HALF_Q;

  // Clamp to [0, 1.0]
  always_comb begin
    if (z_scaled[Z_WIDTH-1]) begin
      sig_value = '0;
    end else if (z_scaled > ONE_Q) begin
      sig_value = ntm_gate_pkg::gate_out_t'(ONE_Q);
    end else begin
      sig_value = ntm_gate_pkg::gate_out_t'(z_scaled);
    end
  end

  // Operand capture and output word
  always_ff @(posedge CLK) begin
    if (input_done) begin
      in_sum_q <= input_sum;
    end
    if (recurrent_done) begin
      rec_sum_q <= recurrent_sum;
    end
    if (bias_enable && busy_q) begin
      bias_q <= bias_in;
    end
    if (all_valid) begin
      gate_out <= sig_value;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // An engine must not deliver the next row before this row is emitted
  one_sum_per_row: assert property (
    @(posedge CLK) disable iff (RST)
    !((input_done && in_valid_q) || (recurrent_done && rec_valid_q))
  );

  // Emitted gate value stays within 1.0
  gate_in_range: assert property (
    @(posedge CLK) disable iff (RST)
    gate_enable |-> (gate_out <= ntm_gate_pkg::gate_out_t'(ONE_Q))
  );

endmodule

//--- design/ntm_gate_defs.svh
// Width definitions for the NTM output gate datapath
`ifndef NTM_GATE_DEFS_SVH
`define NTM_GATE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Operand format
////////////////////////////////////////////////////////////////////////////

// Operand word, Q8.8 signed
`define NTM_DATA_WIDTH 16

// Fraction bits of one operand
`define NTM_FRAC_BITS 8

////////////////////////////////////////////////////////////////////////////
// Accumulation and sizes
////////////////////////////////////////////////////////////////////////////

// Partial sums at 2^-16 resolution
// 32-bit product plus 8 bits of headroom for up to 255 terms
`define NTM_ACC_WIDTH 40

// Row count and element count fields
`define NTM_SIZE_WIDTH 8

`endif

//--- design/ntm_gate_pkg.sv
// Data types shared by the dot-product engines, the combiner and the top level
`include "ntm_gate_defs.svh"

package ntm_gate_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Datapath words
  //////////////////////////////////////////////////////////////////////////

  // W, x, U, h and b operands
  // Q8.8 two's complement
  typedef logic signed [`NTM_DATA_WIDTH-1:0] gate_data_t;

  // Row partial sum
  // Exact sum of products, LSB is 2^-16
  typedef logic signed [`NTM_ACC_WIDTH-1:0] gate_acc_t;

  //////////////////////////////////////////////////////////////////////////
  // Control fields
  //////////////////////////////////////////////////////////////////////////

  // Element count per row, or row count per run
  typedef logic [`NTM_SIZE_WIDTH-1:0] gate_size_t;

  // Gate output in Q8.8
  // Unsigned since the hard sigmoid stays within 0 to 1.0 (0 to 256)
  typedef logic [`NTM_DATA_WIDTH-1:0] gate_out_t;

endpackage

//--- design/ntm_output_gate_vector.sv
// Output gate top level with input and recurrent dot-product engines feeding the combiner
`timescale 1ns/10ps

module ntm_output_gate_vector (
  // Clock and reset
  input  logic                     CLK,
  input  logic                     RST,

  // Run control
  input  logic                     START,
  output logic                     READY,

  // Run sizes, sampled at an accepted START
  input  ntm_gate_pkg::gate_size_t SIZE_X_IN,
  input  ntm_gate_pkg::gate_size_t SIZE_L_IN,

  // Input path, W row against x
  input  ntm_gate_pkg::gate_data_t W_IN,
  input  ntm_gate_pkg::gate_data_t X_IN,
  input  logic                     X_IN_ENABLE,

  // Recurrent path, U row against h
  input  ntm_gate_pkg::gate_data_t U_IN,
  input  ntm_gate_pkg::gate_data_t H_IN,
  input  logic                     H_IN_ENABLE,

  // Bias, one per row
  input  ntm_gate_pkg::gate_data_t B_IN,
  input  logic                     B_IN_ENABLE,

  // Gate value per row
  output ntm_gate_pkg::gate_out_t  O_OUT,
  output logic                     O_OUT_ENABLE
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  // Accepted START to both engines
  logic                    run_start;

  // W.x partial sum
  logic                    input_done;
  ntm_gate_pkg::gate_acc_t input_sum;

  // U.h partial sum
  logic                    recurrent_done;
  ntm_gate_pkg::gate_acc_t recurrent_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Dot-product engines
  ////////////////////////////////////////////////////////////////////////////

  // W(l) . x, SIZE_X_IN elements per row
  ntm_row_dot_product input_product (
    .CLK         (CLK),
    .RST         (RST),
    .run_start   (run_start),
    .size        (SIZE_X_IN),
    .data_enable (X_IN_ENABLE),
    .matrix_in   (W_IN),
    .vector_in   (X_IN),
    .row_done    (input_done),
    .row_sum     (input_sum)
  );

  // U(l) . h, square matrix so SIZE_L_IN elements per row
  ntm_row_dot_product recurrent_product (
    .CLK         (CLK),
    .RST         (RST),
    .run_start   (run_start),
    .size        (SIZE_L_IN),
    .data_enable (H_IN_ENABLE),
    .matrix_in   (U_IN),
    .vector_in   (H_IN),
    .row_done    (recurrent_done),
    .row_sum     (recurrent_sum)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Combiner
  ////////////////////////////////////////////////////////////////////////////

  // Adds both sums and the bias, one output per row, SIZE_L_IN rows
  ntm_gate_combiner gate_combiner (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .size_rows      (SIZE_L_IN),
    .run_start      (run_start),
    .input_done     (input_done),
    .input_sum      (input_sum),
    .recurrent_done (recurrent_done),
    .recurrent_sum  (recurrent_sum),
    .bias_enable    (B_IN_ENABLE),
    .bias_in        (B_IN),
    .gate_enable    (O_OUT_ENABLE),
    .gate_out       (O_OUT),
    .READY          (READY)
  );

endmodule

//--- design/ntm_row_dot_product.sv
// Row dot-product engine that accumulates one matrix row against one vector per row
`timescale 1ns/10ps
`include "ntm_gate_defs.svh"

module ntm_row_dot_product (
  // Clock and reset
  input  logic                     CLK,
  input  logic                     RST,

  // Run control
  input  logic                     run_start,
  input  ntm_gate_pkg::gate_size_t size,

  // Element stream, matrix element paired with vector element
  input  logic                     data_enable,
  input  ntm_gate_pkg::gate_data_t matrix_in,
  input  ntm_gate_pkg::gate_data_t vector_in,

  // Row result
  output logic                     row_done,
  output ntm_gate_pkg::gate_acc_t  row_sum
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  // Full-precision product width
  localparam int PROD_WIDTH = 2 * `NTM_DATA_WIDTH;

  // Elements per row, held for the whole run
  ntm_gate_pkg::gate_size_t size_q;

  // Elements taken so far in this row
  ntm_gate_pkg::gate_size_t count_q;
  ntm_gate_pkg::gate_size_t count_next;

  // Running sum of the row
  ntm_gate_pkg::gate_acc_t  acc_q;
  ntm_gate_pkg::gate_acc_t  acc_next;

  logic signed [PROD_WIDTH-1:0] product;

  // Current pair closes the row
  logic last_elem;

  ////////////////////////////////////////////////////////////////////////////
  // Multiply and accumulate
  ////////////////////////////////////////////////////////////////////////////

  // Q8.8 x Q8.8 gives Q16.16, kept exact
  assign product = matrix_in * vector_in;

  // Sign extend product into the accumulator
  assign acc_next = acc_q + ntm_gate_pkg::gate_acc_t'(product);

  assign count_next = count_q + ntm_gate_pkg::gate_size_t'(1);

  // run_start wins over a stray pair in the same cycle
  assign last_elem = data_enable && !run_start && (count_next == size_q);

  // Control state and accumulator
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_q   <= '0;
      count_q  <= '0;
      acc_q    <= '0;
      row_done <= 1'b0;
    end else begin
      // Single-cycle strobe by default
      row_done <= 1'b0;

      if (run_start) begin
        // New run, take the row length
        size_q  <= size;
        count_q <= '0;
        acc_q   <= '0;
      end else if (data_enable) begin
        if (last_elem) begin
          // Row complete, start the next row clean
          count_q  <= '0;
          acc_q    <= '0;
          row_done <= 1'b1;
        end else begin
          count_q <= count_next;
          acc_q   <= acc_next;
        end
      end
    end
  end

  // Result register, valid with row_done
  always_ff @(posedge CLK) begin
    if (last_elem) begin
      row_sum <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Element count never passes the latched row length
  // Pairs with no run started push it past a zero length
  count_within_size: assert property (
    @(posedge CLK) disable iff (RST)
    count_q <= size_q
  );

endmodule

//--- project.f
+incdir+design
design/ntm_gate_pkg.sv
design/ntm_row_dot_product.sv
design/ntm_gate_combiner.sv
design/ntm_output_gate_vector.sv
verification/ntm_output_gate_vector_tb.sv

//--- verification/ntm_output_gate_vector_tb.sv
// Testbench for the NTM output gate, streams rows and checks gate values against a model
`timescale 1ns/10ps
`include "ntm_gate_defs.svh"

module ntm_output_gate_vector_tb;

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  logic CLK;
  logic RST;
  logic START;
  logic READY;
  ntm_gate_pkg::gate_size_t SIZE_X_IN;
  ntm_gate_pkg::gate_size_t SIZE_L_IN;
  ntm_gate_pkg::gate_data_t W_IN;
  ntm_gate_pkg::gate_data_t X_IN;
  logic X_IN_ENABLE;
  ntm_gate_pkg::gate_data_t U_IN;
  ntm_gate_pkg::gate_data_t H_IN;
  logic H_IN_ENABLE;
  ntm_gate_pkg::gate_data_t B_IN;
  logic B_IN_ENABLE;
  ntm_gate_pkg::gate_out_t O_OUT;
  logic O_OUT_ENABLE;

  // Operands of the row being streamed
  ntm_gate_pkg::gate_data_t w_row [0:15];
  ntm_gate_pkg::gate_data_t x_vec [0:15];
  ntm_gate_pkg::gate_data_t u_row [0:15];
  ntm_gate_pkg::gate_data_t h_vec [0:15];
  ntm_gate_pkg::gate_data_t bias;

  // Model results in row order, out_idx points at the next one due
  int exp_values [0:255];
  int exp_count = 0;
  int out_idx = 0;
  int run_end = 0;
  int expected_o;
  bit start_seen = 1'b0;
  string test_name;
  int sx;
  int sl;
  int r;

  ntm_output_gate_vector UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    if (O_OUT_ENABLE) begin
      out_idx <= out_idx + 1;
    end
  end

  assign expected_o = (out_idx < exp_count) ? exp_values[out_idx] : -1;

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic show_mismatch(input int expected, input int actual);
    $display("ERR %s expected %0d actual %0d", test_name, expected, actual);
    $display("tests failed");
    $fatal(1, "gate value mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%s (test %s)", what, test_name);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Reset and idle, nothing comes out before the first START
  quiet_before_start: assert property (
    @(posedge CLK) !start_seen |-> (!READY && !O_OUT_ENABLE)
  ) else abort_run("READY or O_OUT_ENABLE active before the first START");

  output_expected: assert property (
    @(posedge CLK) disable iff (RST) O_OUT_ENABLE |-> (out_idx < exp_count)
  ) else abort_run("Gate output with no row pending");

  output_value: assert property (
    @(posedge CLK) disable iff (RST) O_OUT_ENABLE |-> (O_OUT == expected_o)
  ) else show_mismatch($sampled(expected_o), $sampled(O_OUT));

  // READY exactly one cycle after the last row of the run
  ready_after_last: assert property (
    @(posedge CLK) disable iff (RST)
    (O_OUT_ENABLE && (out_idx == run_end - 1)) |=> READY
  ) else abort_run("READY missing one cycle after the last gate output");

  ready_only_after_last: assert property (
    @(posedge CLK) disable iff (RST)
    READY |-> ($past(O_OUT_ENABLE) && (out_idx == run_end))
  ) else abort_run("READY outside the cycle after the last gate output");

  ////////////////////////////////////////////////////////////////////////////
  // Model and stimulus
  ////////////////////////////////////////////////////////////////////////////

  // z at 2^-16, then floor(z / 2^10) + 1/2, clamped to [0, 1.0]
  function automatic int model_gate(input int nx, input int nl);
    longint z;
    longint q;
    int i;
    z = longint'(bias) * (longint'(1) << `NTM_FRAC_BITS);
    for (i = 0; i < nx; i++) begin
      z += longint'(w_row[i]) * longint'(x_vec[i]);
    end
    for (i = 0; i < nl; i++) begin
      z += longint'(u_row[i]) * longint'(h_vec[i]);
    end
    q = z / 1024;
    if ((z < 0) && (z % 1024 != 0)) begin
      q = q - 1;
    end
    q = q + 128;
    if (q < 0) return 0;
    if (q > 256) return 256;
    return int'(q);
  endfunction

  // Value within +/-0.5 in Q8.8
  function automatic ntm_gate_pkg::gate_data_t small_operand();
    return ntm_gate_pkg::gate_data_t'(int'($urandom % 256) - 128);
  endfunction

  task automatic load_random_row();
    int i;
    for (i = 0; i < 16; i++) begin
      w_row[i] = small_operand();
      x_vec[i] = small_operand();
      u_row[i] = small_operand();
      h_vec[i] = small_operand();
    end
    bias = small_operand();
  endtask

  task automatic load_constant_row(input ntm_gate_pkg::gate_data_t w,
                                   input ntm_gate_pkg::gate_data_t x,
                                   input ntm_gate_pkg::gate_data_t u,
                                   input ntm_gate_pkg::gate_data_t h,
                                   input ntm_gate_pkg::gate_data_t b);
    int i;
    for (i = 0; i < 16; i++) begin
      w_row[i] = w;
      x_vec[i] = x;
      u_row[i] = u;
      h_vec[i] = h;
    end
    bias = b;
  endtask

  // Polls a strobe at each rising edge, READY or O_OUT_ENABLE
  task automatic wait_for_pulse(input bit want_ready, input int limit);
    int cycles;
    cycles = 0;
    while (1) begin
      @(posedge CLK);
      if (want_ready ? READY : O_OUT_ENABLE) break;
      cycles++;
      if (cycles >= limit) begin
        abort_run(want_ready ? "Timeout waiting for READY" :
                               "Timeout waiting for a gate output");
      end
    end
  endtask

  // Accepted START, sizes held for the run
  task automatic begin_run(input int nx, input int nl);
    #1;
    START = 1'b1;
    SIZE_X_IN = ntm_gate_pkg::gate_size_t'(nx);
    SIZE_L_IN = ntm_gate_pkg::gate_size_t'(nl);
    start_seen = 1'b1;
    run_end = exp_count + nl;
    @(posedge CLK);
    #1 START = 1'b0;
    @(posedge CLK);
  endtask

  // Both element streams and the bias, optionally with random gaps
  task automatic stream_row(input int nx, input int nl, input bit paced);
    int xi;
    int hi;
    int cyc;
    int bias_at;
    bit bias_sent;
    xi = 0;
    hi = 0;
    cyc = 0;
    bias_sent = 1'b0;
    bias_at = $urandom % (((nx > nl) ? nx : nl) + 2);
    while ((xi < nx) || (hi < nl) || !bias_sent) begin
      #1;
      X_IN_ENABLE = 1'b0;
      H_IN_ENABLE = 1'b0;
      B_IN_ENABLE = 1'b0;
      if ((xi < nx) && (!paced || ($urandom % 2 == 0))) begin
        W_IN = w_row[xi];
        X_IN = x_vec[xi];
        X_IN_ENABLE = 1'b1;
        xi++;
      end
      if ((hi < nl) && (!paced || ($urandom % 2 == 0))) begin
        U_IN = u_row[hi];
        H_IN = h_vec[hi];
        H_IN_ENABLE = 1'b1;
        hi++;
      end
      if (!bias_sent && (cyc >= bias_at)) begin
        B_IN = bias;
        B_IN_ENABLE = 1'b1;
        bias_sent = 1'b1;
      end
      @(posedge CLK);
      cyc++;
    end
    #1;
    X_IN_ENABLE = 1'b0;
    H_IN_ENABLE = 1'b0;
    B_IN_ENABLE = 1'b0;
  endtask

  task automatic run_row(input int nx, input int nl, input bit paced);
    exp_values[exp_count] = model_gate(nx, nl);
    exp_count++;
    stream_row(nx, nl, paced);
    wait_for_pulse(1'b0, 60);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h0908_3f55));
    RST = 1'b1;
    START = 1'b0;
    SIZE_X_IN = '0;
    SIZE_L_IN = '0;
    W_IN = '0;
    X_IN = '0;
    X_IN_ENABLE = 1'b0;
    U_IN = '0;
    H_IN = '0;
    H_IN_ENABLE = 1'b0;
    B_IN = '0;
    B_IN_ENABLE = 1'b0;
    test_name = "reset";
    repeat (8) @(posedge CLK);
    #1 RST = 1'b0;
    repeat (4) @(posedge CLK);

    // 1.5*0.5*2 - 0.5*0.25 - 1.0 = 0.375
    test_name = "known_values";
    begin_run(2, 1);
    load_constant_row(16'h0180, 16'h0080, 16'hFF80, 16'h0040, 16'hFF00);
    run_row(2, 1, 1'b0);
    wait_for_pulse(1'b1, 20);

    // Largest products of either sign
    test_name = "saturation";
    begin_run(4, 2);
    load_constant_row(16'h7F00, 16'h7F00, 16'h7F00, 16'h7F00, 16'h7F00);
    run_row(4, 2, 1'b1);
    load_constant_row(16'h7F00, 16'h8100, 16'h7F00, 16'h8100, 16'h8100);
    run_row(4, 2, 1'b1);
    wait_for_pulse(1'b1, 20);

    test_name = "random_run";
    sx = 1 + $urandom % 8;
    sl = 2 + $urandom % 6;
    begin_run(sx, sl);
    for (r = 0; r < sl; r++) begin
      load_random_row();
      run_row(sx, sl, 1'b1);
    end
    wait_for_pulse(1'b1, 20);

    // Second START mid-run with other sizes
    test_name = "start_while_busy";
    begin_run(3, 4);
    for (r = 0; r < 4; r++) begin
      load_random_row();
      run_row(3, 4, 1'b1);
      if (r == 0) begin
        #1;
        START = 1'b1;
        SIZE_X_IN = 8'd1;
        SIZE_L_IN = 8'd7;
        @(posedge CLK);
        #1;
        START = 1'b0;
        SIZE_X_IN = 8'd3;
        SIZE_L_IN = 8'd4;
        @(posedge CLK);
      end
    end
    wait_for_pulse(1'b1, 20);

    // Idle tail catches any stray output
    repeat (10) @(posedge CLK);
    if (out_idx != exp_count) begin
      abort_run("Number of gate outputs differs from the number of rows");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule
